// File: src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN       = 32;  // data and address width
    localparam int ILEN       = 32;  // instruction word width
    localparam int REG_ADDR_W = 5;   // x0..x31
    localparam int OPCODE_W   = 7;

    localparam logic [OPCODE_W-1:0] OPC_OP     = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OPC_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OPC_JALR   = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OPC_LUI    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OPC_AUIPC  = 7'b0010111;

    // zero encoding is ALU so a cleared payload decodes as a plain bubble
    typedef enum logic [2:0] {
        CLASS_ALU,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_BRANCH,
        CLASS_JAL,
        CLASS_JALR,
        CLASS_LUI,
        CLASS_AUIPC
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [ILEN-1:0]       inst;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
        logic [REG_ADDR_W-1:0] rs1;
        logic                  rs1_re;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  rs2_re;
        logic [XLEN-1:0]       imm;       // sign extended
        op_class_e             op_class;
        alu_op_e               alu_op;
        logic                  use_imm;   // second operand is imm
        logic                  illegal;
    } dec_info_t;

endpackage

`default_nettype wire

// File: src/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

    // one command per pipeline register
    typedef struct packed {
        logic stall;  // keep current contents
        logic flush;  // load zero payload, beats stall
    } stage_cmd_t;

    // what fetch hands to decode
    typedef struct packed {
        logic                            valid;
        logic [rv_isa_pkg::XLEN-1:0]     pc;
        logic [rv_isa_pkg::ILEN-1:0]     inst;
    } fetch_t;

endpackage

`default_nettype wire

// File: src/dec_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded instruction leaving the decoder
interface dec_bus_if;

    rv_isa_pkg::dec_info_t info;

    modport producer (
        output info       // decoder fills every field
    );

    modport hazard (
        input  info       // register indices, read enables and valid
    );

    modport consumer (
        input  info       // whole payload into ID/EX
    );

endinterface

`default_nettype wire

// File: src/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input wire pipe_ctrl_pkg::fetch_t fetch_i,
    dec_bus_if.producer               dec
);

    logic [rv_isa_pkg::ILEN-1:0]     inst;
    logic [rv_isa_pkg::OPCODE_W-1:0] opcode;
    logic [2:0]                      funct3;
    logic                            is_op;
    logic                            funct7_zero;
    logic                            funct7_alt;
    logic [rv_isa_pkg::XLEN-1:0]     imm_i;
    logic [rv_isa_pkg::XLEN-1:0]     imm_s;
    logic [rv_isa_pkg::XLEN-1:0]     imm_b;
    logic [rv_isa_pkg::XLEN-1:0]     imm_u;
    logic [rv_isa_pkg::XLEN-1:0]     imm_j;
    rv_isa_pkg::alu_op_e             arith_op;
    logic                            arith_bad;
    rv_isa_pkg::dec_info_t           info;

    assign inst        = fetch_i.inst;
    assign opcode      = inst[6:0];
    assign funct3      = inst[14:12];
    assign is_op       = (opcode == rv_isa_pkg::OPC_OP);
    assign funct7_zero = (inst[31:25] == 7'b0000000);
    assign funct7_alt  = (inst[31:25] == 7'b0100000);  // SUB / SRA

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct3 map shared by OP and OP-IMM
    always_comb begin
        arith_bad = 1'b0;
        case (funct3)
            3'b000: begin
                arith_op  = (is_op && funct7_alt) ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
                arith_bad = is_op && !funct7_zero && !funct7_alt;
            end
            3'b001: begin
                arith_op  = rv_isa_pkg::ALU_SLL;
                arith_bad = !funct7_zero;  // shamt[5] set too
            end
            3'b010: begin
                arith_op  = rv_isa_pkg::ALU_SLT;
                arith_bad = is_op && !funct7_zero;
            end
            3'b011: begin
                arith_op  = rv_isa_pkg::ALU_SLTU;
                arith_bad = is_op && !funct7_zero;
            end
            3'b100: begin
                arith_op  = rv_isa_pkg::ALU_XOR;
                arith_bad = is_op && !funct7_zero;
            end
            3'b101: begin
                arith_op  = funct7_alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
                arith_bad = !funct7_zero && !funct7_alt;
            end
            3'b110: begin
                arith_op  = rv_isa_pkg::ALU_OR;
                arith_bad = is_op && !funct7_zero;
            end
            default: begin
                arith_op  = rv_isa_pkg::ALU_AND;
                arith_bad = is_op && !funct7_zero;
            end
        endcase
    end

    always_comb begin
        info          = '0;
        info.valid    = fetch_i.valid;
        info.pc       = fetch_i.pc;
        info.inst     = inst;
        info.rd       = inst[11:7];
        info.rs1      = inst[19:15];
        info.rs2      = inst[24:20];
        info.op_class = rv_isa_pkg::CLASS_ALU;
        info.alu_op   = rv_isa_pkg::ALU_ADD;  // address adds for non-ALU classes

        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                info.rs1_re  = 1'b1;
                info.rs2_re  = 1'b1;
                info.rd_we   = 1'b1;
                info.alu_op  = arith_op;
                info.illegal = arith_bad;
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                info.rs1_re  = 1'b1;
                info.rd_we   = 1'b1;
                info.imm     = imm_i;
                info.use_imm = 1'b1;
                info.alu_op  = arith_op;
                info.illegal = arith_bad;
            end
            rv_isa_pkg::OPC_LOAD: begin
                info.op_class = rv_isa_pkg::CLASS_LOAD;
                info.rs1_re   = 1'b1;
                info.rd_we    = 1'b1;
                info.imm      = imm_i;
                info.use_imm  = 1'b1;
            end
            rv_isa_pkg::OPC_STORE: begin
                info.op_class = rv_isa_pkg::CLASS_STORE;
                info.rs1_re   = 1'b1;
                info.rs2_re   = 1'b1;
                info.imm      = imm_s;
                info.use_imm  = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                info.op_class = rv_isa_pkg::CLASS_BRANCH;
                info.rs1_re   = 1'b1;
                info.rs2_re   = 1'b1;
                info.imm      = imm_b;   // target offset, ALU compares regs
                info.alu_op   = rv_isa_pkg::ALU_SUB;
            end
            rv_isa_pkg::OPC_JAL: begin
                info.op_class = rv_isa_pkg::CLASS_JAL;
                info.rd_we    = 1'b1;
                info.imm      = imm_j;
                info.use_imm  = 1'b1;
            end
            rv_isa_pkg::OPC_JALR: begin
                info.op_class = rv_isa_pkg::CLASS_JALR;
                info.rs1_re   = 1'b1;
                info.rd_we    = 1'b1;
                info.imm      = imm_i;
                info.use_imm  = 1'b1;
            end
            rv_isa_pkg::OPC_LUI: begin
                info.op_class = rv_isa_pkg::CLASS_LUI;
                info.rd_we    = 1'b1;
                info.imm      = imm_u;
                info.use_imm  = 1'b1;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                info.op_class = rv_isa_pkg::CLASS_AUIPC;
                info.rd_we    = 1'b1;
                info.imm      = imm_u;
                info.use_imm  = 1'b1;
            end
            default: begin
                info.illegal = 1'b1;  // CSR, FENCE, ECALL land here too
            end
        endcase

        if (info.rd == '0) begin
            info.rd_we = 1'b0;  // writes to x0 are dropped
        end

        // illegal keeps valid and register fields, nothing else
        if (info.illegal) begin
            info.rd_we    = 1'b0;
            info.rs1_re   = 1'b0;
            info.rs2_re   = 1'b0;
            info.imm      = '0;
            info.use_imm  = 1'b0;
            info.op_class = rv_isa_pkg::CLASS_ALU;
            info.alu_op   = rv_isa_pkg::ALU_ADD;
        end

        if (!fetch_i.valid) begin
            info.rd_we   = 1'b0;  // bubble requests nothing
            info.rs1_re  = 1'b0;
            info.rs2_re  = 1'b0;
            info.illegal = 1'b0;
        end
    end

    assign dec.info = info;

endmodule

`default_nettype wire

// File: src/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire                            clk,
    input  wire                            rst_i,
    input  wire pipe_ctrl_pkg::stage_cmd_t cmd_i,
    input  wire payload_t                  d_i,
    output payload_t                       q_o
);

    // reset and flush share the zero payload, flush beats stall
    always_ff @(posedge clk) begin
        if (rst_i || cmd_i.flush) begin
            q_o <= '0;
        end else if (!cmd_i.stall) begin
            q_o <= d_i;  // valid travels with the payload
        end
    end

endmodule

`default_nettype wire

// File: src/pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
    input  wire                        redirect_i,
    input  wire rv_isa_pkg::dec_info_t ex_info_i,
    dec_bus_if.hazard                  hz,
    output pipe_ctrl_pkg::stage_cmd_t  if_id_cmd_o,
    output pipe_ctrl_pkg::stage_cmd_t  id_ex_cmd_o,
    output logic                       stall_o
);

    logic ex_is_load;
    logic rs1_hit;
    logic rs2_hit;
    logic load_use;

    // load data not ready until after execute
    assign ex_is_load = ex_info_i.valid && ex_info_i.rd_we &&
                        (ex_info_i.op_class == rv_isa_pkg::CLASS_LOAD);

    assign rs1_hit  = hz.info.rs1_re && (hz.info.rs1 == ex_info_i.rd);
    assign rs2_hit  = hz.info.rs2_re && (hz.info.rs2 == ex_info_i.rd);
    assign load_use = ex_is_load && hz.info.valid && (rs1_hit || rs2_hit);

    always_comb begin
        if_id_cmd_o = '0;
        id_ex_cmd_o = '0;
        if (redirect_i) begin
            if_id_cmd_o.flush = 1'b1;  // both younger items are wrong path
            id_ex_cmd_o.flush = 1'b1;
        end else if (load_use) begin
            if_id_cmd_o.stall = 1'b1;  // consumer waits in decode
            id_ex_cmd_o.flush = 1'b1;  // one bubble into execute
        end
    end

    assign stall_o = load_use && !redirect_i;

endmodule

`default_nettype wire

// File: src/decode_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_top (
    input  wire                                 clk,
    input  wire                                 rst_i,
    input  wire                                 fetch_valid_i,
    input  wire [rv_isa_pkg::XLEN-1:0]          fetch_pc_i,
    input  wire [rv_isa_pkg::ILEN-1:0]          fetch_inst_i,
    input  wire                                 redirect_i,     // one-cycle pulse from execute
    output wire                                 stall_o,        // upstream must hold inputs
    output wire                                 ex_valid_o,
    output wire [rv_isa_pkg::XLEN-1:0]          ex_pc_o,
    output wire [rv_isa_pkg::ILEN-1:0]          ex_inst_o,
    output wire [rv_isa_pkg::REG_ADDR_W-1:0]    ex_rd_o,
    output wire                                 ex_rd_we_o,
    output wire [rv_isa_pkg::REG_ADDR_W-1:0]    ex_rs1_o,
    output wire                                 ex_rs1_re_o,
    output wire [rv_isa_pkg::REG_ADDR_W-1:0]    ex_rs2_o,
    output wire                                 ex_rs2_re_o,
    output wire [rv_isa_pkg::XLEN-1:0]          ex_imm_o,
    output rv_isa_pkg::op_class_e               ex_op_class_o,
    output rv_isa_pkg::alu_op_e                 ex_alu_op_o,
    output wire                                 ex_use_imm_o,
    output wire                                 ex_illegal_o
);

    pipe_ctrl_pkg::fetch_t     fetch_in;
    pipe_ctrl_pkg::fetch_t     fetch_q;     // IF/ID contents
    rv_isa_pkg::dec_info_t     ex_info;     // ID/EX contents
    pipe_ctrl_pkg::stage_cmd_t if_id_cmd;
    pipe_ctrl_pkg::stage_cmd_t id_ex_cmd;

    dec_bus_if dec_bus ();

    assign fetch_in.valid = fetch_valid_i;
    assign fetch_in.pc    = fetch_pc_i;
    assign fetch_in.inst  = fetch_inst_i;

    pipe_reg #(
        .payload_t (pipe_ctrl_pkg::fetch_t)
    ) if_id_reg (
        .clk   (clk),
        .rst_i (rst_i),
        .cmd_i (if_id_cmd),
        .d_i   (fetch_in),
        .q_o   (fetch_q)
    );

    inst_decoder decoder (
        .fetch_i (fetch_q),
        .dec     (dec_bus.producer)
    );

    // consumer side of the bus, whole payload registered
    pipe_reg #(
        .payload_t (rv_isa_pkg::dec_info_t)
    ) id_ex_reg (
        .clk   (clk),
        .rst_i (rst_i),
        .cmd_i (id_ex_cmd),
        .d_i   (dec_bus.info),
        .q_o   (ex_info)
    );

    pipe_ctrl ctrl (
        .redirect_i  (redirect_i),
        .ex_info_i   (ex_info),
        .hz          (dec_bus.hazard),
        .if_id_cmd_o (if_id_cmd),
        .id_ex_cmd_o (id_ex_cmd),
        .stall_o     (stall_o)
    );

    assign ex_valid_o    = ex_info.valid;
    assign ex_pc_o       = ex_info.pc;
    assign ex_inst_o     = ex_info.inst;
    assign ex_rd_o       = ex_info.rd;
    assign ex_rd_we_o    = ex_info.rd_we;
    assign ex_rs1_o      = ex_info.rs1;
    assign ex_rs1_re_o   = ex_info.rs1_re;
    assign ex_rs2_o      = ex_info.rs2;
    assign ex_rs2_re_o   = ex_info.rs2_re;
    assign ex_imm_o      = ex_info.imm;
    assign ex_op_class_o = ex_info.op_class;
    assign ex_alu_op_o   = ex_info.alu_op;
    assign ex_use_imm_o  = ex_info.use_imm;
    assign ex_illegal_o  = ex_info.illegal;

endmodule

`default_nettype wire

// File: tb/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;  // 20 ns period
    end

endmodule

`default_nettype wire

// File: tb/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic        valid;
        logic        redir;  // redirect pulse while this row is presented
    } row_t;

    localparam logic [31:0] irs_mask   = 32'hFFFF_8F80;  // imm, rs1, rs2 and rd bits
    localparam logic [31:0] upper_mask = 32'hFFFF_FF80;  // everything but the opcode
    localparam int drain_cycles = 4;
    localparam rv_isa_pkg::alu_op_e f3_ops [8] = '{rv_isa_pkg::ALU_ADD, rv_isa_pkg::ALU_SLL,
        rv_isa_pkg::ALU_SLT, rv_isa_pkg::ALU_SLTU, rv_isa_pkg::ALU_XOR, rv_isa_pkg::ALU_SRL,
        rv_isa_pkg::ALU_OR, rv_isa_pkg::ALU_AND};

    logic clk;
    logic rst_i;
    logic fetch_valid_i;
    logic [31:0] fetch_pc_i;
    logic [31:0] fetch_inst_i;
    logic redirect_i;
    logic stall_o;
    logic ex_valid_o;
    logic [31:0] ex_pc_o;
    logic [31:0] ex_inst_o;
    logic [4:0] ex_rd_o;
    logic ex_rd_we_o;
    logic [4:0] ex_rs1_o;
    logic ex_rs1_re_o;
    logic [4:0] ex_rs2_o;
    logic ex_rs2_re_o;
    logic [31:0] ex_imm_o;
    rv_isa_pkg::op_class_e ex_op_class_o;
    rv_isa_pkg::alu_op_e ex_alu_op_o;
    logic ex_use_imm_o;
    logic ex_illegal_o;

    row_t rows[$];
    logic table_ready = 1'b0;
    pipe_ctrl_pkg::fetch_t model_ifid;   // expected IF/ID contents
    rv_isa_pkg::dec_info_t model_idex;   // expected ID/EX contents

    clk_gen clock (.clk_o(clk));

    decode_stage_top uut (
        .clk(clk), .rst_i(rst_i), .fetch_valid_i(fetch_valid_i), .fetch_pc_i(fetch_pc_i),
        .fetch_inst_i(fetch_inst_i), .redirect_i(redirect_i), .stall_o(stall_o),
        .ex_valid_o(ex_valid_o), .ex_pc_o(ex_pc_o), .ex_inst_o(ex_inst_o), .ex_rd_o(ex_rd_o),
        .ex_rd_we_o(ex_rd_we_o), .ex_rs1_o(ex_rs1_o), .ex_rs1_re_o(ex_rs1_re_o),
        .ex_rs2_o(ex_rs2_o), .ex_rs2_re_o(ex_rs2_re_o), .ex_imm_o(ex_imm_o),
        .ex_op_class_o(ex_op_class_o), .ex_alu_op_o(ex_alu_op_o), .ex_use_imm_o(ex_use_imm_o),
        .ex_illegal_o(ex_illegal_o)
    );

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // expected decode of one fetch item, straight from the RV32I encoding rules
    function automatic rv_isa_pkg::dec_info_t ref_decode(input pipe_ctrl_pkg::fetch_t f);
        rv_isa_pkg::dec_info_t e;
        logic [31:0] w;
        logic [31:0] imm_i;
        logic [12:0] boff;
        logic [6:0] f7;
        logic [2:0] f3;
        logic shift;
        w = f.inst;
        f7 = w[31:25];
        f3 = w[14:12];
        imm_i = {{20{w[31]}}, w[31:20]};
        shift = (f3 == 3'd1) || (f3 == 3'd5);
        e = '0;
        e.valid = f.valid;
        e.pc = f.pc;
        e.inst = w;
        e.rd = w[11:7];
        e.rs1 = w[19:15];
        e.rs2 = w[24:20];
        e.op_class = rv_isa_pkg::CLASS_ALU;
        e.alu_op = rv_isa_pkg::ALU_ADD;
        case (w[6:0])
            rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM: begin
                e.rs1_re = 1'b1;
                e.rd_we = 1'b1;
                e.rs2_re = (w[6:0] == rv_isa_pkg::OPC_OP);
                e.use_imm = !e.rs2_re;
                e.imm = e.use_imm ? imm_i : 32'h0;
                e.alu_op = f3_ops[f3];
                if (f7 == 7'h20 && f3 == 3'd5)
                    e.alu_op = rv_isa_pkg::ALU_SRA;
                if (f7 == 7'h20 && f3 == 3'd0 && e.rs2_re)
                    e.alu_op = rv_isa_pkg::ALU_SUB;
                if (shift)
                    e.illegal = !(f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20));
                else
                    e.illegal = e.rs2_re && !(f7 == 7'h00 || (f3 == 3'd0 && f7 == 7'h20));
            end
            rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_JALR: begin
                e.op_class = (w[6:0] == rv_isa_pkg::OPC_LOAD) ? rv_isa_pkg::CLASS_LOAD
                                                              : rv_isa_pkg::CLASS_JALR;
                e.rs1_re = 1'b1;
                e.rd_we = 1'b1;
                e.use_imm = 1'b1;
                e.imm = imm_i;
            end
            rv_isa_pkg::OPC_STORE: begin
                e.op_class = rv_isa_pkg::CLASS_STORE;
                e.rs1_re = 1'b1;
                e.rs2_re = 1'b1;
                e.use_imm = 1'b1;
                e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            rv_isa_pkg::OPC_BRANCH: begin
                e.op_class = rv_isa_pkg::CLASS_BRANCH;
                e.rs1_re = 1'b1;
                e.rs2_re = 1'b1;
                e.alu_op = rv_isa_pkg::ALU_SUB;   // compare by subtraction
                boff = {w[31], w[7], w[30:25], w[11:8], 1'b0};
                e.imm = {{19{boff[12]}}, boff};
            end
            rv_isa_pkg::OPC_JAL: begin
                e.op_class = rv_isa_pkg::CLASS_JAL;
                e.rd_we = 1'b1;
                e.use_imm = 1'b1;
                e.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: begin
                e.op_class = (w[6:0] == rv_isa_pkg::OPC_LUI) ? rv_isa_pkg::CLASS_LUI
                                                             : rv_isa_pkg::CLASS_AUIPC;
                e.rd_we = 1'b1;
                e.use_imm = 1'b1;
                e.imm = {w[31:12], 12'h000};
            end
            default: e.illegal = 1'b1;
        endcase
        if (e.rd == 5'd0)
            e.rd_we = 1'b0;
        if (e.illegal) begin  // only valid, pc, inst and register indices survive
            e.rd_we = 1'b0;
            e.rs1_re = 1'b0;
            e.rs2_re = 1'b0;
            e.imm = '0;
            e.use_imm = 1'b0;
            e.op_class = rv_isa_pkg::CLASS_ALU;
            e.alu_op = rv_isa_pkg::ALU_ADD;
        end
        if (!f.valid) begin
            e.rd_we = 1'b0;
            e.rs1_re = 1'b0;
            e.rs2_re = 1'b0;
            e.illegal = 1'b0;
        end
        return e;
    endfunction

    task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("Fail at %0t ns: %s expected %h, actual %h", $time, name, exp_v, act_v);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic add_row(input logic [31:0] inst, input logic [31:0] rmask,
                           input logic valid, input logic redir);
        row_t r;
        r.inst = (inst & ~rmask) | ($urandom() & rmask);
        r.pc = 32'h0000_0100 + 32'(4 * rows.size());
        r.valid = valid;
        r.redir = redir;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(rtype(7'h20, 6, 5, 0, 4, rv_isa_pkg::OPC_OP), 0, 1, 0);       // sub
        for (int k = 0; k < 8; k++)
            add_row(rtype(0, 5'(k + 3), 5'(k + 1), 3'(k), 5'(k + 9), rv_isa_pkg::OPC_OP), 0, 1, 0);
        add_row(rtype(7'h20, 3, 2, 5, 1, rv_isa_pkg::OPC_OP), 0, 1, 0);       // sra
        add_row(rtype(7'h01, 3, 2, 0, 1, rv_isa_pkg::OPC_OP), 0, 1, 0);       // mul, not RV32I
        for (int k = 0; k < 8; k++)
            if (k != 1 && k != 5)
                add_row(itype(0, 0, 3'(k), 0, rv_isa_pkg::OPC_OP_IMM), irs_mask, 1, 0);
        add_row(rtype(0, 5, 4, 1, 3, rv_isa_pkg::OPC_OP_IMM), 0, 1, 0);       // slli
        add_row(rtype(0, 7, 4, 5, 3, rv_isa_pkg::OPC_OP_IMM), 0, 1, 0);       // srli
        add_row(rtype(7'h20, 7, 4, 5, 6, rv_isa_pkg::OPC_OP_IMM), 0, 1, 0);   // srai
        add_row(rtype(7'h20, 1, 4, 1, 3, rv_isa_pkg::OPC_OP_IMM), 0, 1, 0);   // bad slli
        add_row(itype(12'hFFF, 2, 0, 1, rv_isa_pkg::OPC_OP_IMM), 0, 1, 0);    // addi -1
        add_row(itype(5, 1, 0, 0, rv_isa_pkg::OPC_OP_IMM), 0, 1, 0);          // rd is x0
        add_row(itype(0, 0, 2, 0, rv_isa_pkg::OPC_LOAD), irs_mask, 1, 0);
        add_row(itype(0, 0, 2, 0, rv_isa_pkg::OPC_STORE), irs_mask, 1, 0);
        add_row(itype(0, 0, 0, 0, rv_isa_pkg::OPC_BRANCH), irs_mask, 1, 0);
        add_row(rtype(7'h40, 2, 1, 1, 0, rv_isa_pkg::OPC_BRANCH), 0, 1, 0);   // backward
        add_row(itype(0, 0, 0, 0, rv_isa_pkg::OPC_JALR), irs_mask, 1, 0);
        add_row({25'h0, rv_isa_pkg::OPC_JAL}, upper_mask, 1, 0);
        add_row({25'h0, rv_isa_pkg::OPC_LUI}, upper_mask, 1, 0);
        add_row({25'h0, rv_isa_pkg::OPC_AUIPC}, upper_mask, 1, 0);
        add_row(32'h0000_0073, 0, 1, 0);                                       // ecall
        add_row(32'h0000_000F, 0, 1, 0);                                       // fence
        add_row(rtype(0, 3, 2, 0, 1, rv_isa_pkg::OPC_OP), 0, 0, 0);           // fetch bubble
        add_row(itype(0, 1, 2, 5, rv_isa_pkg::OPC_LOAD), 0, 1, 0);            // lw x5
        add_row(rtype(0, 7, 5, 0, 6, rv_isa_pkg::OPC_OP), 0, 1, 0);           // uses x5
        add_row(itype(4, 2, 2, 8, rv_isa_pkg::OPC_LOAD), 0, 1, 0);            // lw x8
        add_row(rtype(0, 8, 3, 2, 4, rv_isa_pkg::OPC_STORE), 0, 1, 0);        // stores x8
        add_row(itype(0, 1, 2, 0, rv_isa_pkg::OPC_LOAD), 0, 1, 0);            // lw x0
        add_row(rtype(0, 0, 0, 0, 2, rv_isa_pkg::OPC_OP), 0, 1, 0);           // reads x0
        add_row(itype(0, 1, 2, 10, rv_isa_pkg::OPC_LOAD), 0, 1, 0);
        add_row(rtype(0, 13, 12, 0, 11, rv_isa_pkg::OPC_OP), 0, 1, 0);        // unrelated
        for (int k = 1; k <= 5; k++)  // third one carries the redirect
            add_row(itype(12'(k), 0, 0, 5'(k), rv_isa_pkg::OPC_OP_IMM), 0, 1, k == 3);
        add_row(itype(0, 1, 2, 5, rv_isa_pkg::OPC_LOAD), 0, 1, 0);
        add_row(rtype(0, 5, 5, 0, 6, rv_isa_pkg::OPC_OP), 0, 1, 0);
        add_row(itype(7, 0, 0, 7, rv_isa_pkg::OPC_OP_IMM), 0, 1, 1);          // redirect on hazard
        add_row(itype(8, 0, 0, 8, rv_isa_pkg::OPC_OP_IMM), 0, 1, 0);
    endtask

    task automatic drive_row(input int i);
        if (i < rows.size()) begin
            fetch_valid_i = rows[i].valid;
            fetch_pc_i = rows[i].pc;
            fetch_inst_i = rows[i].inst;
            redirect_i = rows[i].redir;
        end else begin
            fetch_valid_i = 1'b0;
            fetch_pc_i = '0;
            fetch_inst_i = '0;
            redirect_i = 1'b0;
        end
    endtask

    // at the rising edge, before the registers move
    task automatic step_model(output logic stalled);
        rv_isa_pkg::dec_info_t dec_now;
        logic hazard;
        dec_now = ref_decode(model_ifid);
        hazard = model_idex.valid && model_idex.rd_we && dec_now.valid &&
                 model_idex.op_class == rv_isa_pkg::CLASS_LOAD &&
                 ((dec_now.rs1_re && dec_now.rs1 == model_idex.rd) ||
                  (dec_now.rs2_re && dec_now.rs2 == model_idex.rd));
        stalled = hazard && !redirect_i;
        check("stall_o", 32'(stalled), 32'(stall_o));
        if (redirect_i) begin
            model_ifid = '0;
            model_idex = '0;
        end else if (hazard) begin
            model_idex = '0;  // bubble, consumer stays in IF/ID
        end else begin
            model_idex = dec_now;
            model_ifid = {fetch_valid_i, fetch_pc_i, fetch_inst_i};
        end
    endtask

    task automatic check_outputs();
        check("ex_valid_o", 32'(model_idex.valid), 32'(ex_valid_o));
        check("ex_rd_we_o", 32'(model_idex.rd_we), 32'(ex_rd_we_o));
        check("ex_rs1_re_o", 32'(model_idex.rs1_re), 32'(ex_rs1_re_o));
        check("ex_rs2_re_o", 32'(model_idex.rs2_re), 32'(ex_rs2_re_o));
        check("ex_illegal_o", 32'(model_idex.illegal), 32'(ex_illegal_o));
        if (model_idex.valid) begin
            check("ex_pc_o", model_idex.pc, ex_pc_o);
            check("ex_inst_o", model_idex.inst, ex_inst_o);
            check("ex_rd_o", 32'(model_idex.rd), 32'(ex_rd_o));
            check("ex_rs1_o", 32'(model_idex.rs1), 32'(ex_rs1_o));
            check("ex_rs2_o", 32'(model_idex.rs2), 32'(ex_rs2_o));
            check("ex_imm_o", model_idex.imm, ex_imm_o);
            check("ex_op_class_o", 32'(model_idex.op_class), 32'(ex_op_class_o));
            check("ex_alu_op_o", 32'(model_idex.alu_op), 32'(ex_alu_op_o));
            check("ex_use_imm_o", 32'(model_idex.use_imm), 32'(ex_use_imm_o));
        end
    endtask

    initial begin : watchdog
        int limit_ns;
        wait (table_ready);
        limit_ns = (rows.size() * 4 + 10 + drain_cycles) * 20;
        #(limit_ns);
        $display("Run timed out after %0t ns before all rows were applied", $time);
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        int idx;
        logic stalled;
        void'($urandom(88));
        rst_i = 1'b1;
        drive_row(rows.size());  // idle inputs during reset
        model_ifid = '0;
        model_idex = '0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        check_outputs();
        check("stall_o", 32'h0, 32'(stall_o));
        idx = 0;
        while (idx < rows.size() + drain_cycles) begin
            drive_row(idx);
            @(posedge clk);
            step_model(stalled);
            @(negedge clk);
            check_outputs();
            if (!stalled)
                idx++;  // held row is presented again
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/rv_isa_pkg.sv
src/pipe_ctrl_pkg.sv
src/dec_bus_if.sv
src/inst_decoder.sv
src/pipe_reg.sv
src/pipe_ctrl.sv
src/decode_stage_top.sv
tb/clk_gen.sv
tb/tb_decode_stage.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_decode_stage -o tb_sim

out=$(./obj_dir/tb_sim 2>&1) || true
echo "$out"

if grep -q "Test completed successfully" <<< "$out"; then
    exit 0
else
    exit 1
fi
